/* all.f */
hdl/bus_pkg.sv
hdl/rx_queue.sv
hdl/bus_sequencer.sv
hdl/data_bus_port.sv
hdl/mem_uart_top.sv
bench/board_model.sv
bench/mem_uart_tb.sv

/* Makefile */
TOP = mem_uart_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

/* bench/mem_uart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_uart_tb;

	localparam int QUEUE_DEPTH_LOG2 = 3;
	localparam int TICK_DIV_LOG2    = 1;
	localparam int DEPTH            = 2 ** QUEUE_DEPTH_LOG2;
	localparam int RAM_WORDS        = 16;
	localparam int TX_BYTES         = 6;
	localparam int RX_BYTES         = 5;
	localparam int OVER_BYTES       = DEPTH + 4;
	// Rough bus steps per item, chip waits included
	localparam int TEST_TICKS  = RAM_WORDS * 2 * 8 + TX_BYTES * 30 +
		(RX_BYTES + OVER_BYTES) * 20 + 20;
	localparam int CYCLE_LIMIT = 2 * TEST_TICKS * (2 ** TICK_DIV_LOG2) + 200;

	logic                      clk;
	logic                      rst;
	logic                      start;
	bus_pkg::mem_req_t         req;
	logic                      busy;
	logic                      done;
	logic [15:0]               rdata;
	logic [QUEUE_DEPTH_LOG2:0] rx_count;
	logic [15:0]               ram_addr;
	wire  [15:0]               ram_data;
	logic                      ram_en_n;
	logic                      ram_oe_n;
	logic                      ram_we_n;
	logic                      data_ready;
	logic                      rdn;
	logic                      wrn;
	logic                      tbre;
	logic                      tsre;
	logic                      feed;
	logic [7:0]                feed_byte;
	logic [7:0]                pending;
	logic [7:0]                tx_count;
	logic [7:0]                last_sent;

	int          errors;
	int          checks;
	int          cycles;
	logic        tx_idle_at_done;
	logic [15:0] ref_mem [256];
	logic [7:0]  fed [$];

	mem_uart_top #(
		.QUEUE_DEPTH_LOG2(QUEUE_DEPTH_LOG2),
		.TICK_DIV_LOG2   (TICK_DIV_LOG2)
	) uut (
		.clk(clk), .rst(rst), .start(start), .req(req),
		.busy(busy), .done(done), .rdata(rdata), .rx_count(rx_count),
		.ram_addr(ram_addr), .ram_data(ram_data),
		.ram_en_n(ram_en_n), .ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n),
		.data_ready(data_ready), .rdn(rdn), .wrn(wrn), .tbre(tbre), .tsre(tsre)
	);

	board_model board (
		.clk(clk), .rst(rst), .ram_addr(ram_addr), .ram_data(ram_data),
		.ram_en_n(ram_en_n), .ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n),
		.data_ready(data_ready), .rdn(rdn), .wrn(wrn), .tbre(tbre), .tsre(tsre),
		.feed(feed), .feed_byte(feed_byte), .pending(pending),
		.tx_count(tx_count), .last_sent(last_sent)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic check_equal(input string test_name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("Error %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic expect_true(input string test_name, input logic cond, input string what);
		checks++;
		assert (cond === 1'b1) else begin
			errors++;
			$display("%s: %s", test_name, what);
		end
	endtask

	function automatic logic [15:0] random_ram_addr();
		logic [15:0] a;
		a = 16'($urandom);
		while (a == bus_pkg::UART_ADDR)
			a = 16'($urandom);
		return a;
	endfunction

	// One CPU access, returns at the cycle after done
	task automatic cpu_access(input string test_name, input bus_pkg::mem_op_e op,
		input logic [15:0] addr, input logic [15:0] wdata, output logic [15:0] result);
		@(negedge clk);
		while (busy)
			@(negedge clk);
		start     = 1'b1;
		req.op    = op;
		req.addr  = addr;
		req.wdata = wdata;
		@(negedge clk);
		start = 1'b0;
		expect_true(test_name, busy, "busy did not rise after start");
		check_equal(test_name, addr, ram_addr);
		while (!done)
			@(negedge clk);
		result          = rdata;
		tx_idle_at_done = tbre && tsre;
		expect_true(test_name, !busy, "busy still high together with done");
		@(negedge clk);
		expect_true(test_name, !done, "done lasted more than one cycle");
	endtask

	task automatic feed_bytes(input int n);
		logic [7:0] b;
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			b         = 8'($urandom);
			feed      = 1'b1;
			feed_byte = b;
			fed.push_back(b);
		end
		@(negedge clk);
		feed = 1'b0;
	endtask

	task automatic wait_pending(input int n);
		while (int'(pending) != n)
			@(negedge clk);
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic sram_readback();
		logic [15:0] addrs [RAM_WORDS];
		logic [15:0] word;
		logic [15:0] got;
		for (int i = 0; i < RAM_WORDS; i++) begin
			addrs[i] = random_ram_addr();
			word     = 16'($urandom);
			// Model SRAM decodes the low address byte only
			ref_mem[addrs[i][7:0]] = word;
			cpu_access("sram_readback", bus_pkg::OP_WRITE, addrs[i], word, got);
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			cpu_access("sram_readback", bus_pkg::OP_READ, addrs[i], 16'h0000, got);
			check_equal("sram_readback", ref_mem[addrs[i][7:0]], got);
		end
	endtask

	task automatic uart_send();
		logic [15:0] word;
		logic [15:0] got;
		logic [7:0]  count_before;
		for (int i = 0; i < TX_BYTES; i++) begin
			word         = 16'($urandom);
			count_before = tx_count;
			cpu_access("uart_send", bus_pkg::OP_WRITE, bus_pkg::UART_ADDR, word, got);
			expect_true("uart_send", tx_idle_at_done, "done came before tbre and tsre were high");
			check_equal("uart_send", 16'(count_before + 8'd1), 16'(tx_count));
			check_equal("uart_send", {8'h00, word[7:0]}, {8'h00, last_sent});
		end
	endtask

	task automatic uart_receive();
		logic [15:0] got;
		logic [7:0]  exp;
		fed.delete();
		feed_bytes(RX_BYTES);
		wait_pending(0);
		check_equal("uart_receive", 16'(RX_BYTES), 16'(rx_count));
		for (int i = 0; i < RX_BYTES; i++) begin
			cpu_access("uart_receive", bus_pkg::OP_READ, bus_pkg::UART_ADDR, 16'h0000, got);
			exp = fed.pop_front();
			check_equal("uart_receive", {8'h00, exp}, got);
			check_equal("uart_receive", 16'(RX_BYTES - 1 - i), 16'(rx_count));
		end
	endtask

	task automatic queue_overflow();
		logic [15:0] got;
		logic [7:0]  exp;
		int          left;
		fed.delete();
		feed_bytes(OVER_BYTES);
		wait_pending(OVER_BYTES - DEPTH);
		// Queue must stay full while the chip still holds bytes
		repeat (8 * (2 ** TICK_DIV_LOG2))
			@(negedge clk);
		check_equal("queue_overflow", 16'(DEPTH), 16'(rx_count));
		check_equal("queue_overflow", 16'(OVER_BYTES - DEPTH), 16'(pending));
		for (int i = 0; i < OVER_BYTES; i++) begin
			cpu_access("queue_overflow", bus_pkg::OP_READ, bus_pkg::UART_ADDR, 16'h0000, got);
			exp = fed.pop_front();
			check_equal("queue_overflow", {8'h00, exp}, got);
			left = OVER_BYTES - 1 - i;
			wait_pending(left > DEPTH ? left - DEPTH : 0);
			check_equal("queue_overflow", 16'(left > DEPTH ? DEPTH : left), 16'(rx_count));
		end
	endtask

	task automatic empty_queue_read();
		logic [15:0] addr;
		logic [15:0] got;
		// Leave a nonzero word in rdata first
		addr = random_ram_addr();
		cpu_access("empty_queue_read", bus_pkg::OP_WRITE, addr, 16'hA5C3, got);
		cpu_access("empty_queue_read", bus_pkg::OP_READ, addr, 16'h0000, got);
		check_equal("empty_queue_read", 16'hA5C3, got);
		check_equal("empty_queue_read", 16'h0000, 16'(rx_count));
		cpu_access("empty_queue_read", bus_pkg::OP_READ, bus_pkg::UART_ADDR, 16'h0000, got);
		check_equal("empty_queue_read", 16'h0000, got);
		check_equal("empty_queue_read", 16'h0000, 16'(rx_count));
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		void'($urandom(12));
		errors          = 0;
		checks          = 0;
		start           = 1'b0;
		req             = '0;
		rst             = 1'b0;
		feed            = 1'b0;
		feed_byte       = 8'h00;
		tx_idle_at_done = 1'b0;
		repeat (10)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		sram_readback();
		uart_send();
		uart_receive();
		queue_overflow();
		empty_queue_read();

		repeat (4)
			@(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not end within %0d cycles, %0d errors so far",
			CYCLE_LIMIT, errors);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/board_model.sv */
`timescale 1ns/1ps
`default_nettype none

module board_model (
	input  wire        clk,
	input  wire        rst,
	input  wire [15:0] ram_addr,
	inout  wire [15:0] ram_data,
	input  wire        ram_en_n,
	input  wire        ram_oe_n,
	input  wire        ram_we_n,
	output logic       data_ready,
	input  wire        rdn,
	input  wire        wrn,
	output logic       tbre,
	output logic       tsre,
	input  wire        feed,
	input  wire  [7:0] feed_byte,
	output logic [7:0] pending,
	output logic [7:0] tx_count,
	output logic [7:0] last_sent
);

	logic [15:0] sram [256];
	logic [7:0]  rx_list [$];
	logic [7:0]  rx_front;
	logic [7:0]  tx_hold;
	logic [3:0]  tx_wait;
	logic [1:0]  tx_phase;
	logic        rdn_q;
	logic        wrn_q;
	logic        drive_en;
	logic [15:0] drive_word;

	// SRAM output enable or UART read strobe
	assign drive_en   = (!ram_en_n && !ram_oe_n) || !rdn;
	assign drive_word = !rdn ? {8'h00, rx_front} : sram[ram_addr[7:0]];
	assign ram_data   = drive_en ? drive_word : 16'hzzzz;

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			rx_list.delete();
			data_ready <= 1'b0;
			rx_front   <= 8'h00;
			pending    <= 8'h00;
			rdn_q      <= 1'b1;
			wrn_q      <= 1'b1;
			tbre       <= 1'b1;
			tsre       <= 1'b1;
			tx_phase   <= 2'd0;
			tx_wait    <= 4'd0;
			tx_hold    <= 8'h00;
			tx_count   <= 8'h00;
			last_sent  <= 8'h00;
		end else begin
			rdn_q <= rdn;
			wrn_q <= wrn;
			if (!ram_en_n && !ram_we_n)
				sram[ram_addr[7:0]] <= ram_data;

			// Front byte leaves once the read strobe ends
			if (rdn && !rdn_q && rx_list.size() != 0)
				void'(rx_list.pop_front());
			if (feed)
				rx_list.push_back(feed_byte);
			data_ready <= (rx_list.size() != 0);
			pending    <= 8'(rx_list.size());
			if (rx_list.size() != 0)
				rx_front <= rx_list[0];

			if (!wrn)
				tx_hold <= ram_data[7:0];
			if (wrn && !wrn_q) begin
				tx_count  <= tx_count + 8'd1;
				last_sent <= tx_hold;
			end

			// Holding register busy, then shift register busy
			case (tx_phase)
				2'd0: begin
					if (!wrn && wrn_q) begin
						tbre     <= 1'b0;
						tx_wait  <= 4'd2 + 4'($urandom % 8);
						tx_phase <= 2'd1;
					end
				end
				2'd1: begin
					if (tx_wait == 4'd0) begin
						tbre     <= 1'b1;
						tsre     <= 1'b0;
						tx_wait  <= 4'd2 + 4'($urandom % 8);
						tx_phase <= 2'd2;
					end else begin
						tx_wait <= tx_wait - 4'd1;
					end
				end
				2'd2: begin
					if (tx_wait == 4'd0) begin
						tsre     <= 1'b1;
						tx_phase <= 2'd0;
					end else begin
						tx_wait <= tx_wait - 4'd1;
					end
				end
				default: tx_phase <= 2'd0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/mem_uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_uart_top #(
	parameter int QUEUE_DEPTH_LOG2 = 3,
	parameter int TICK_DIV_LOG2    = 1
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          start,
	input  bus_pkg::mem_req_t            req,
	output logic                         busy,
	output logic                         done,
	output logic [bus_pkg::DATA_W-1:0]   rdata,
	output logic [QUEUE_DEPTH_LOG2:0]    rx_count,
	output logic [bus_pkg::ADDR_W-1:0]   ram_addr,
	inout  wire  [bus_pkg::DATA_W-1:0]   ram_data,
	output logic                         ram_en_n,
	output logic                         ram_oe_n,
	output logic                         ram_we_n,
	input  wire                          data_ready,
	output logic                         rdn,
	output logic                         wrn,
	input  wire                          tbre,
	input  wire                          tsre
);

	bus_pkg::bus_ctrl_t ctrl;
	bus_pkg::mem_req_t  cur_req;

	logic                       capture;
	logic                       result_sel;
	logic                       push;
	logic                       pop;
	logic                       queue_full;
	logic                       queue_empty;
	logic [bus_pkg::BYTE_W-1:0] head_byte;

	//////////////////////////////
	// Receive queue
	//////////////////////////////

	// Received byte sits in the low byte of rdata after capture
	rx_queue #(
		.QUEUE_DEPTH_LOG2(QUEUE_DEPTH_LOG2)
	) u_rx_queue (
		.clk       (clk),
		.rst       (rst),
		.push      (push),
		.push_byte (rdata[bus_pkg::BYTE_W-1:0]),
		.pop       (pop),
		.head_byte (head_byte),
		.count     (rx_count),
		.full      (queue_full),
		.empty     (queue_empty)
	);

	bus_sequencer #(
		.TICK_DIV_LOG2(TICK_DIV_LOG2)
	) u_bus_sequencer (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.req         (req),
		.data_ready  (data_ready),
		.tbre        (tbre),
		.tsre        (tsre),
		.queue_full  (queue_full),
		.queue_empty (queue_empty),
		.busy        (busy),
		.done        (done),
		.ctrl        (ctrl),
		.cur_req     (cur_req),
		.capture     (capture),
		.result_sel  (result_sel),
		.push        (push),
		.pop         (pop)
	);

	data_bus_port u_data_bus_port (
		.clk         (clk),
		.rst         (rst),
		.ctrl        (ctrl),
		.cur_req     (cur_req),
		.capture     (capture),
		.result_sel  (result_sel),
		.queue_head  (head_byte),
		.queue_empty (queue_empty),
		.ram_addr    (ram_addr),
		.ram_en_n    (ram_en_n),
		.ram_oe_n    (ram_oe_n),
		.ram_we_n    (ram_we_n),
		.rdn         (rdn),
		.wrn         (wrn),
		.ram_data    (ram_data),
		.rdata       (rdata)
	);

endmodule

`default_nettype wire

/* hdl/data_bus_port.sv */
`timescale 1ns/1ps
`default_nettype none

module data_bus_port (
	input  wire                          clk,
	input  wire                          rst,
	input  bus_pkg::bus_ctrl_t           ctrl,
	input  bus_pkg::mem_req_t            cur_req,
	input  wire                          capture,
	input  wire                          result_sel,
	input  wire  [bus_pkg::BYTE_W-1:0]   queue_head,
	input  wire                          queue_empty,
	output logic [bus_pkg::ADDR_W-1:0]   ram_addr,
	output logic                         ram_en_n,
	output logic                         ram_oe_n,
	output logic                         ram_we_n,
	output logic                         rdn,
	output logic                         wrn,
	inout  wire  [bus_pkg::DATA_W-1:0]   ram_data,
	output logic [bus_pkg::DATA_W-1:0]   rdata
);

	localparam int PAD_W = bus_pkg::DATA_W - bus_pkg::BYTE_W;

	logic [bus_pkg::DATA_W-1:0] bus_value;

	// Shared data bus
	assign ram_data = ctrl.drive ? cur_req.wdata : {bus_pkg::DATA_W{1'bz}};
	assign ram_addr = cur_req.addr;

	assign ram_en_n = ctrl.ram_en_n;
	assign ram_oe_n = ctrl.ram_oe_n;
	assign ram_we_n = ctrl.ram_we_n;
	assign rdn      = ctrl.rdn;
	assign wrn      = ctrl.wrn;

	// UART drives only the low byte
	assign bus_value = ctrl.rdn ? ram_data : {{PAD_W{1'b0}}, ram_data[bus_pkg::BYTE_W-1:0]};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rdata <= '0;
		end else if (capture) begin
			if (!result_sel)
				rdata <= bus_value;
			else if (queue_empty)
				rdata <= '0;
			else
				rdata <= {{PAD_W{1'b0}}, queue_head};
		end
	end

endmodule

`default_nettype wire

/* hdl/bus_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer #(
	parameter int TICK_DIV_LOG2 = 1
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 start,
	input  bus_pkg::mem_req_t   req,
	input  wire                 data_ready,
	input  wire                 tbre,
	input  wire                 tsre,
	input  wire                 queue_full,
	input  wire                 queue_empty,
	output logic                busy,
	output logic                done,
	output bus_pkg::bus_ctrl_t  ctrl,
	output bus_pkg::mem_req_t   cur_req,
	output logic                capture,
	output logic                result_sel,
	output logic                push,
	output logic                pop
);

	localparam logic [TICK_DIV_LOG2:0] TICK_LAST = (TICK_DIV_LOG2+1)'(2 ** TICK_DIV_LOG2 - 1);

	bus_pkg::seq_state_e state;
	bus_pkg::seq_state_e next_state;

	logic [TICK_DIV_LOG2:0] div_cnt;
	logic                   tick;
	logic                   is_uart;
	logic                   finish;

	//////////////////////////////
	// Bus step tick
	//////////////////////////////

	assign tick = (div_cnt == TICK_LAST);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			div_cnt <= '0;
		else if (tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// Request latch
	always_ff @(posedge clk) begin
		if (start)
			cur_req <= req;
	end

	assign is_uart = (cur_req.addr == bus_pkg::UART_ADDR);

	//////////////////////////////
	// State machine
	//////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			bus_pkg::IDLE: begin
				// Incoming byte wins over a waiting CPU access
				if (data_ready && !queue_full) begin
					next_state = bus_pkg::RX_WAIT;
				end else if (busy) begin
					if (is_uart)
						next_state = (cur_req.op == bus_pkg::OP_WRITE) ?
							bus_pkg::TX_DRIVE : bus_pkg::QUEUE_RD;
					else
						next_state = (cur_req.op == bus_pkg::OP_WRITE) ?
							bus_pkg::RAM_WR_SETUP : bus_pkg::RAM_RD_SETUP;
				end
			end
			bus_pkg::RX_WAIT: begin
				if (data_ready)
					next_state = bus_pkg::RX_STROBE;
			end
			bus_pkg::RX_STROBE:    next_state = bus_pkg::RX_TAKE;
			bus_pkg::RX_TAKE:      next_state = bus_pkg::RX_END;
			bus_pkg::RX_END:       next_state = bus_pkg::IDLE;
			bus_pkg::TX_DRIVE:     next_state = bus_pkg::TX_HOLD;
			bus_pkg::TX_HOLD:      next_state = bus_pkg::TX_WAIT_TBRE;
			bus_pkg::TX_WAIT_TBRE: begin
				if (tbre)
					next_state = bus_pkg::TX_WAIT_TSRE;
			end
			bus_pkg::TX_WAIT_TSRE: begin
				if (tsre)
					next_state = bus_pkg::TX_END;
			end
			bus_pkg::TX_END:       next_state = bus_pkg::IDLE;
			bus_pkg::RAM_RD_SETUP: next_state = bus_pkg::RAM_RD_HOLD;
			bus_pkg::RAM_RD_HOLD:  next_state = bus_pkg::RAM_RD_TAKE;
			bus_pkg::RAM_RD_TAKE:  next_state = bus_pkg::IDLE;
			bus_pkg::RAM_WR_SETUP: next_state = bus_pkg::RAM_WR_PULSE;
			bus_pkg::RAM_WR_PULSE: next_state = bus_pkg::RAM_WR_END;
			bus_pkg::RAM_WR_END:   next_state = bus_pkg::IDLE;
			bus_pkg::QUEUE_RD:     next_state = bus_pkg::QUEUE_END;
			bus_pkg::QUEUE_END:    next_state = bus_pkg::IDLE;
			default:               next_state = bus_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			state <= bus_pkg::IDLE;
		else if (tick)
			state <= next_state;
	end

	// Last step of each CPU access
	assign finish = tick && (state == bus_pkg::RAM_RD_TAKE || state == bus_pkg::RAM_WR_END ||
		state == bus_pkg::TX_END || state == bus_pkg::QUEUE_END);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= finish;
			if (finish)
				busy <= 1'b0;
			else if (start)
				busy <= 1'b1;
		end
	end

	assign capture = tick && (state == bus_pkg::RAM_RD_TAKE ||
		state == bus_pkg::RX_STROBE || state == bus_pkg::QUEUE_RD);
	assign result_sel = (state == bus_pkg::QUEUE_RD);
	assign push = tick && (state == bus_pkg::RX_TAKE);
	// Empty queue read returns zero and leaves pointers alone
	assign pop = tick && (state == bus_pkg::QUEUE_END) && !queue_empty;

	//////////////////////////////
	// Strobe pattern per state
	//////////////////////////////

	always_comb begin
		ctrl = '{ram_en_n: 1'b1, ram_oe_n: 1'b1, ram_we_n: 1'b1,
			rdn: 1'b1, wrn: 1'b1, drive: 1'b0};
		case (state)
			bus_pkg::RX_STROBE, bus_pkg::RX_TAKE: ctrl.rdn = 1'b0;
			bus_pkg::TX_DRIVE, bus_pkg::TX_WAIT_TBRE: ctrl.drive = 1'b1;
			bus_pkg::TX_HOLD: begin
				ctrl.drive = 1'b1;
				ctrl.wrn   = 1'b0;
			end
			bus_pkg::RAM_RD_SETUP, bus_pkg::RAM_RD_HOLD, bus_pkg::RAM_RD_TAKE: begin
				ctrl.ram_en_n = 1'b0;
				ctrl.ram_oe_n = 1'b0;
			end
			bus_pkg::RAM_WR_SETUP, bus_pkg::RAM_WR_END: begin
				ctrl.ram_en_n = 1'b0;
				ctrl.drive    = 1'b1;
			end
			bus_pkg::RAM_WR_PULSE: begin
				ctrl.ram_en_n = 1'b0;
				ctrl.ram_we_n = 1'b0;
				ctrl.drive    = 1'b1;
			end
			default: ;
		endcase
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!rst) start |-> !busy);
	a_uart_excl: assert property (@(posedge clk) disable iff (!rst) ctrl.rdn || ctrl.wrn);
	a_no_contend: assert property (@(posedge clk) disable iff (!rst)
		!(ctrl.drive && !ctrl.ram_oe_n));

endmodule

`default_nettype wire

/* hdl/rx_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_queue #(
	parameter int QUEUE_DEPTH_LOG2 = 3
) (
	input  wire                             clk,
	input  wire                             rst,
	input  wire                             push,
	input  wire  [bus_pkg::BYTE_W-1:0]      push_byte,
	input  wire                             pop,
	output logic [bus_pkg::BYTE_W-1:0]      head_byte,
	output logic [QUEUE_DEPTH_LOG2:0]       count,
	output logic                            full,
	output logic                            empty
);

	localparam int DEPTH = 2 ** QUEUE_DEPTH_LOG2;

	logic [bus_pkg::BYTE_W-1:0] mem [DEPTH];

	// Pointers carry one wrap bit above the index
	logic [QUEUE_DEPTH_LOG2:0] wr_ptr;
	logic [QUEUE_DEPTH_LOG2:0] rd_ptr;

	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign count = wr_ptr - rd_ptr;
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[QUEUE_DEPTH_LOG2] != rd_ptr[QUEUE_DEPTH_LOG2]) &&
		(wr_ptr[QUEUE_DEPTH_LOG2-1:0] == rd_ptr[QUEUE_DEPTH_LOG2-1:0]);

	assign head_byte = mem[rd_ptr[QUEUE_DEPTH_LOG2-1:0]];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr[QUEUE_DEPTH_LOG2-1:0]] <= push_byte;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Sequencer only receives while there is room
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst) push |-> !full);
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst) pop |-> !empty);

endmodule

`default_nettype wire

/* hdl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;
	localparam int BYTE_W = 8;

	// Single address decoded to the UART chip
	localparam logic [ADDR_W-1:0] UART_ADDR = 16'hBF00;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} mem_op_e;

	typedef enum logic [4:0] {
		IDLE,
		RX_WAIT,
		RX_STROBE,
		RX_TAKE,
		RX_END,
		TX_DRIVE,
		TX_HOLD,
		TX_WAIT_TBRE,
		TX_WAIT_TSRE,
		TX_END,
		RAM_RD_SETUP,
		RAM_RD_HOLD,
		RAM_RD_TAKE,
		RAM_WR_SETUP,
		RAM_WR_PULSE,
		RAM_WR_END,
		QUEUE_RD,
		QUEUE_END
	} seq_state_e;

	// One CPU access
	typedef struct packed {
		mem_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

	// Chip strobes are active low except drive
	typedef struct packed {
		logic ram_en_n;
		logic ram_oe_n;
		logic ram_we_n;
		logic rdn;
		logic wrn;
		logic drive;
	} bus_ctrl_t;

endpackage

`default_nettype wire
